// ==== hwpe_pkg.sv ====
// Shared definitions for the accelerator subsystem: address map, widths,
// control and memory request/response structs, engine state and owner enums
package hwpe_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  // Register offsets, decoded on address bits 7:0
  localparam logic [7:0] RegTrigger = 8'h00;
  localparam logic [7:0] RegStatus  = 8'h04;
  localparam logic [7:0] RegSrc     = 8'h08;
  localparam logic [7:0] RegDst     = 8'h0C;
  localparam logic [7:0] RegLen     = 8'h10;
  localparam logic [7:0] RegFactor  = 8'h14;
  localparam logic [7:0] RegOwner   = 8'h98;
  localparam logic [7:0] RegClkEn   = 8'h9C;

  localparam int unsigned EngineSelBit = 8;
  localparam int unsigned MaxLen       = 255;

  typedef struct packed {
    logic                 valid;
    logic                 write;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } ctrl_req_t;

  typedef struct packed {
    logic                 ready;
    logic                 rvalid;
    logic [DataWidth-1:0] rdata;
  } ctrl_rsp_t;

  typedef struct packed {
    logic                 valid;
    logic                 write;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                 ready;
    logic                 rvalid;
    logic [DataWidth-1:0] rdata;
  } mem_rsp_t;

  typedef enum logic [2:0] {IDLE, RD_REQ, RD_WAIT, WR_REQ, FINISH} engine_state_e;

  typedef enum logic {OWN_SCALE, OWN_COPY} owner_e;

endpackage

// ==== mem_port_mux.sv ====
// Static two-to-one memory-port mux with an outstanding-read counter
// that holds the active owner until all reads have returned
`timescale 1ns/1ps

module mem_port_mux (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  hwpe_pkg::owner_e   owner_i,
  input  hwpe_pkg::mem_req_t eng_req_i [2],
  output hwpe_pkg::mem_rsp_t eng_rsp_o [2],
  output hwpe_pkg::mem_req_t mem_req_o,
  input  hwpe_pkg::mem_rsp_t mem_rsp_i
);
  import hwpe_pkg::*;

  owner_e     active_q;
  logic [1:0] pending_q, pending_d;
  logic       rd_acc;

  assign mem_req_o = eng_req_i[active_q];

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      eng_rsp_o[i].ready  = (active_q == owner_e'(i)) && mem_rsp_i.ready;
      eng_rsp_o[i].rvalid = (active_q == owner_e'(i)) && mem_rsp_i.rvalid;
      eng_rsp_o[i].rdata  = mem_rsp_i.rdata;
    end
  end

  assign rd_acc    = mem_req_o.valid && !mem_req_o.write && mem_rsp_i.ready;
  assign pending_d = pending_q + {1'b0, rd_acc} - {1'b0, mem_rsp_i.rvalid};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
      active_q  <= OWN_SCALE;
    end else begin
      pending_q <= pending_d;
      // Switch only once every issued read has come back
      if (pending_d == '0) begin
        active_q <= owner_i;
      end
    end
  end

endmodule

// ==== scale_engine.sv ====
// Scale engine: src, dst, len and factor registers and a sequencer that
// reads each word, multiplies it by the factor and writes it back
`timescale 1ns/1ps

module scale_engine (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                en_i,
  input  hwpe_pkg::ctrl_req_t ctrl_req_i,
  output hwpe_pkg::ctrl_rsp_t ctrl_rsp_o,
  output hwpe_pkg::mem_req_t  mem_req_o,
  input  hwpe_pkg::mem_rsp_t  mem_rsp_i,
  output logic                busy_o,
  output logic                done_o
);
  import hwpe_pkg::*;

  engine_state_e                  state_q;
  logic [AddrWidth-1:0]           src_q, dst_q;
  logic [DataWidth-1:0]           factor_q, data_q, rd_val, rdata_q;
  logic [$clog2(MaxLen+1)-1:0]    len_q, idx_q;
  logic [AddrWidth-1:0]           offset;
  logic                           cfg_wr, start, last, mem_hs, rvalid_q;

  assign cfg_wr = en_i && ctrl_req_i.valid && ctrl_req_i.write;
  assign start  = cfg_wr && (ctrl_req_i.addr[7:0] == RegTrigger) && ctrl_req_i.wdata[0]
                  && (state_q == IDLE);
  assign offset = AddrWidth'({idx_q, 2'b00});
  assign last   = (idx_q == len_q - 1'b1);
  assign mem_hs = mem_req_o.valid && mem_rsp_i.ready;

  assign busy_o = (state_q != IDLE);
  assign done_o = en_i && (state_q == FINISH);

  assign mem_req_o.valid = en_i && ((state_q == RD_REQ) || (state_q == WR_REQ));
  assign mem_req_o.write = (state_q == WR_REQ);
  assign mem_req_o.addr  = (state_q == WR_REQ) ? dst_q + offset : src_q + offset;
  assign mem_req_o.wdata = data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      src_q    <= '0;
      dst_q    <= '0;
      len_q    <= '0;
      factor_q <= '0;
    end else if (cfg_wr) begin
      case (ctrl_req_i.addr[7:0])
        RegSrc:    src_q    <= ctrl_req_i.wdata;
        RegDst:    dst_q    <= ctrl_req_i.wdata;
        RegLen:    len_q    <= ctrl_req_i.wdata[$bits(len_q)-1:0];
        RegFactor: factor_q <= ctrl_req_i.wdata;
        default: ;
      endcase
    end
  end

  always_comb begin
    rd_val = '0;
    case (ctrl_req_i.addr[7:0])
      RegStatus: rd_val = {{(DataWidth-1){1'b0}}, busy_o};
      RegSrc:    rd_val = src_q;
      RegDst:    rd_val = dst_q;
      RegLen:    rd_val = DataWidth'(len_q);
      RegFactor: rd_val = factor_q;
      default:   rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else if (en_i) begin
      rvalid_q <= ctrl_req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (en_i && ctrl_req_i.valid) begin
      rdata_q <= ctrl_req_i.write ? '0 : rd_val;
    end
  end

  assign ctrl_rsp_o.ready  = en_i;
  assign ctrl_rsp_o.rvalid = rvalid_q;
  assign ctrl_rsp_o.rdata  = rdata_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      idx_q   <= '0;
    end else begin
      case (state_q)
        IDLE: if (start) begin
          idx_q   <= '0;
          state_q <= (len_q == '0) ? FINISH : RD_REQ;
        end
        RD_REQ:  if (mem_hs) state_q <= RD_WAIT;
        // A read already issued must still land
        RD_WAIT: if (mem_rsp_i.rvalid) state_q <= WR_REQ;
        WR_REQ: if (mem_hs) begin
          if (last) begin
            state_q <= FINISH;
          end else begin
            idx_q   <= idx_q + 1'b1;
            state_q <= RD_REQ;
          end
        end
        FINISH:  if (en_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Product held until the write is accepted
  always_ff @(posedge clk_i) begin
    if ((state_q == RD_WAIT) && mem_rsp_i.rvalid) begin
      data_q <= mem_rsp_i.rdata * factor_q;
    end
  end

endmodule

// ==== copy_engine.sv ====
// Copy engine: src, dst and len registers and a sequencer that moves
// a block of words unchanged
`timescale 1ns/1ps

module copy_engine (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                en_i,
  input  hwpe_pkg::ctrl_req_t ctrl_req_i,
  output hwpe_pkg::ctrl_rsp_t ctrl_rsp_o,
  output hwpe_pkg::mem_req_t  mem_req_o,
  input  hwpe_pkg::mem_rsp_t  mem_rsp_i,
  output logic                busy_o,
  output logic                done_o
);
  import hwpe_pkg::*;

  engine_state_e               state_q;
  logic [AddrWidth-1:0]        src_q, dst_q, offset;
  logic [DataWidth-1:0]        data_q, rd_val, rdata_q;
  logic [$clog2(MaxLen+1)-1:0] len_q, idx_q;
  logic                        cfg_wr, start, last, mem_hs, rvalid_q;

  assign cfg_wr = en_i && ctrl_req_i.valid && ctrl_req_i.write;
  assign start  = cfg_wr && (ctrl_req_i.addr[7:0] == RegTrigger) && ctrl_req_i.wdata[0]
                  && (state_q == IDLE);
  assign offset = AddrWidth'({idx_q, 2'b00});
  assign last   = (idx_q == len_q - 1'b1);
  assign mem_hs = mem_req_o.valid && mem_rsp_i.ready;

  assign busy_o = (state_q != IDLE);
  assign done_o = en_i && (state_q == FINISH);

  assign mem_req_o.valid = en_i && ((state_q == RD_REQ) || (state_q == WR_REQ));
  assign mem_req_o.write = (state_q == WR_REQ);
  assign mem_req_o.addr  = (state_q == WR_REQ) ? dst_q + offset : src_q + offset;
  assign mem_req_o.wdata = data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      src_q <= '0;
      dst_q <= '0;
      len_q <= '0;
    end else if (cfg_wr) begin
      case (ctrl_req_i.addr[7:0])
        RegSrc:  src_q <= ctrl_req_i.wdata;
        RegDst:  dst_q <= ctrl_req_i.wdata;
        RegLen:  len_q <= ctrl_req_i.wdata[$bits(len_q)-1:0];
        default: ;
      endcase
    end
  end

  // No factor here, RegFactor falls to zero
  always_comb begin
    case (ctrl_req_i.addr[7:0])
      RegStatus: rd_val = {{(DataWidth-1){1'b0}}, busy_o};
      RegSrc:    rd_val = src_q;
      RegDst:    rd_val = dst_q;
      RegLen:    rd_val = DataWidth'(len_q);
      default:   rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else if (en_i) begin
      rvalid_q <= ctrl_req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (en_i && ctrl_req_i.valid) begin
      rdata_q <= ctrl_req_i.write ? '0 : rd_val;
    end
  end

  assign ctrl_rsp_o.ready  = en_i;
  assign ctrl_rsp_o.rvalid = rvalid_q;
  assign ctrl_rsp_o.rdata  = rdata_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      idx_q   <= '0;
    end else begin
      case (state_q)
        IDLE: if (start) begin
          idx_q   <= '0;
          state_q <= (len_q == '0) ? FINISH : RD_REQ;
        end
        RD_REQ:  if (mem_hs) state_q <= RD_WAIT;
        RD_WAIT: if (mem_rsp_i.rvalid) state_q <= WR_REQ;
        WR_REQ: if (mem_hs) begin
          idx_q   <= last ? idx_q : idx_q + 1'b1;
          state_q <= last ? FINISH : RD_REQ;
        end
        FINISH:  if (en_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == RD_WAIT) && mem_rsp_i.rvalid) begin
      data_q <= mem_rsp_i.rdata;
    end
  end

endmodule

// ==== hwpe_subsystem.sv ====
// Accelerator subsystem top: control decode, owner and enable registers,
// scale and copy engines sharing one memory port
`timescale 1ns/1ps

module hwpe_subsystem (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  hwpe_pkg::ctrl_req_t  ctrl_req_i,
  output hwpe_pkg::ctrl_rsp_t  ctrl_rsp_o,
  output hwpe_pkg::mem_req_t   mem_req_o,
  input  hwpe_pkg::mem_rsp_t   mem_rsp_i,
  output logic [1:0]           busy_o,
  output logic [1:0]           done_o
);
  import hwpe_pkg::*;

  owner_e               owner_q;
  logic [1:0]           en_q;
  logic                 local_hit;
  logic                 eng_sel;
  logic                 eng_hit;
  logic                 accept;
  logic                 loc_rvalid_q;
  logic [DataWidth-1:0] loc_rdata_q;
  logic [DataWidth-1:0] loc_rdata;

  ctrl_req_t eng_ctrl_req [2];
  ctrl_rsp_t eng_ctrl_rsp [2];
  mem_req_t  eng_mem_req  [2];
  mem_rsp_t  eng_mem_rsp  [2];

  assign local_hit = (ctrl_req_i.addr[7:0] == RegOwner) || (ctrl_req_i.addr[7:0] == RegClkEn);
  assign eng_sel   = ctrl_req_i.addr[EngineSelBit];
  assign eng_hit   = !local_hit && en_q[eng_sel];
  assign accept    = ctrl_req_i.valid && ctrl_rsp_o.ready;

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      eng_ctrl_req[i]       = ctrl_req_i;
      eng_ctrl_req[i].valid = ctrl_req_i.valid && eng_hit && (eng_sel == i[0]);
    end
  end

  always_comb begin
    loc_rdata = '0;
    if (!ctrl_req_i.write) begin
      if (ctrl_req_i.addr[7:0] == RegOwner) begin
        loc_rdata = {{(DataWidth-1){1'b0}}, owner_q};
      end else if (ctrl_req_i.addr[7:0] == RegClkEn) begin
        loc_rdata = {{(DataWidth-2){1'b0}}, en_q};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      owner_q <= OWN_SCALE;
      en_q    <= '0;
    end else if (accept && local_hit && ctrl_req_i.write) begin
      if (ctrl_req_i.addr[7:0] == RegOwner) begin
        owner_q <= owner_e'(ctrl_req_i.wdata[0]);
      end else begin
        en_q <= ctrl_req_i.wdata[1:0];
      end
    end
  end

  // Local registers and disabled engines answer here
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      loc_rvalid_q <= 1'b0;
    end else begin
      loc_rvalid_q <= accept && !eng_hit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && !eng_hit) begin
      loc_rdata_q <= local_hit ? loc_rdata : '0;
    end
  end

  always_comb begin
    ctrl_rsp_o.ready  = eng_hit ? eng_ctrl_rsp[eng_sel].ready : 1'b1;
    ctrl_rsp_o.rvalid = loc_rvalid_q | eng_ctrl_rsp[0].rvalid | eng_ctrl_rsp[1].rvalid;
    ctrl_rsp_o.rdata  = ({DataWidth{loc_rvalid_q}} & loc_rdata_q)
                      | ({DataWidth{eng_ctrl_rsp[0].rvalid}} & eng_ctrl_rsp[0].rdata)
                      | ({DataWidth{eng_ctrl_rsp[1].rvalid}} & eng_ctrl_rsp[1].rdata);
  end

  scale_engine i_scale_engine (
    .clk_i      ( clk_i           ),
    .rst_ni     ( rst_ni          ),
    .en_i       ( en_q[0]         ),
    .ctrl_req_i ( eng_ctrl_req[0] ),
    .ctrl_rsp_o ( eng_ctrl_rsp[0] ),
    .mem_req_o  ( eng_mem_req[0]  ),
    .mem_rsp_i  ( eng_mem_rsp[0]  ),
    .busy_o     ( busy_o[0]       ),
    .done_o     ( done_o[0]       )
  );

  copy_engine i_copy_engine (
    .clk_i      ( clk_i           ),
    .rst_ni     ( rst_ni          ),
    .en_i       ( en_q[1]         ),
    .ctrl_req_i ( eng_ctrl_req[1] ),
    .ctrl_rsp_o ( eng_ctrl_rsp[1] ),
    .mem_req_o  ( eng_mem_req[1]  ),
    .mem_rsp_i  ( eng_mem_rsp[1]  ),
    .busy_o     ( busy_o[1]       ),
    .done_o     ( done_o[1]       )
  );

  mem_port_mux i_mem_port_mux (
    .clk_i      ( clk_i       ),
    .rst_ni     ( rst_ni      ),
    .owner_i    ( owner_q     ),
    .eng_req_i  ( eng_mem_req ),
    .eng_rsp_o  ( eng_mem_rsp ),
    .mem_req_o  ( mem_req_o   ),
    .mem_rsp_i  ( mem_rsp_i   )
  );

endmodule

// ==== tb_hwpe_assert.sv ====
// Assertions on the subsystem ports: control response timing,
// single-cycle done pulses, memory port quiet while idle
`timescale 1ns/1ps

module tb_hwpe_assert (
  input logic                clk_i,
  input logic                rst_ni,
  input hwpe_pkg::ctrl_req_t ctrl_req_i,
  input hwpe_pkg::ctrl_rsp_t ctrl_rsp_o,
  input hwpe_pkg::mem_req_t  mem_req_o,
  input logic [1:0]          busy_o,
  input logic [1:0]          done_o
);

  logic accept;

  assign accept = ctrl_req_i.valid && ctrl_rsp_o.ready;

  rsp_after_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |=> ctrl_rsp_o.rvalid) else $error("control response missing after accept");

  no_rsp_without_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !accept |=> !ctrl_rsp_o.rvalid) else $error("control response without a request");

  scale_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o[0] |=> !done_o[0]) else $error("scale done held for two cycles");

  copy_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o[1] |=> !done_o[1]) else $error("copy done held for two cycles");

  mem_quiet_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (busy_o == 2'b00) |-> !mem_req_o.valid) else $error("memory request while both idle");

endmodule

// ==== tb_hwpe_subsystem.sv ====
// Testbench for the accelerator subsystem: clock, reset, memory model,
// directed tests, compare tasks and timeout
`timescale 1ns/1ps

module tb_hwpe_subsystem;
  import hwpe_pkg::*;

  localparam int unsigned MemWords = 1024;
  // Longest test is about 3 runs of 64 words at under 10 cycles each, with a wide margin
  localparam int unsigned MaxCycles = 20000;
  localparam logic [AddrWidth-1:0] CopyBase = 32'h100;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  ctrl_req_t  ctrl_req;
  ctrl_rsp_t  ctrl_rsp;
  mem_req_t   mem_req;
  mem_rsp_t   mem_rsp;
  logic [1:0] busy;
  logic [1:0] done;

  logic [DataWidth-1:0] mem     [MemWords];
  logic [DataWidth-1:0] exp_mem [MemWords];
  logic [DataWidth-1:0] rd_data_q [$];
  int                   rd_due_q  [$];
  int                   cycle    = 0;
  int                   wr_count = 0;
  int                   copy_acc = 0;
  int                   copy_lo  = 0;
  int                   copy_hi  = 0;
  string                test_name;

  hwpe_subsystem UUT (
    .clk_i      ( clk_i    ),
    .rst_ni     ( rst_ni   ),
    .ctrl_req_i ( ctrl_req ),
    .ctrl_rsp_o ( ctrl_rsp ),
    .mem_req_o  ( mem_req  ),
    .mem_rsp_i  ( mem_rsp  ),
    .busy_o     ( busy     ),
    .done_o     ( done     )
  );

  always #5 clk_i = ~clk_i;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_word(input string what, input logic [DataWidth-1:0] exp,
                            input logic [DataWidth-1:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_bits(input string what, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("[FAIL] %s %s: expected %b, actual %b", test_name, what, exp, act));
    end
  endtask

  // Memory accepts on the rising edge, read data returns 1 to 3 cycles later
  always @(posedge clk_i) begin
    if (rst_ni && mem_req.valid && mem_rsp.ready) begin
      if (int'(mem_req.addr[11:2]) >= copy_lo && int'(mem_req.addr[11:2]) < copy_hi) begin
        copy_acc++;
      end
      if (mem_req.write) begin
        mem[mem_req.addr[11:2]] = mem_req.wdata;
        wr_count++;
      end else begin
        rd_data_q.push_back(mem[mem_req.addr[11:2]]);
        rd_due_q.push_back(cycle + 1 + int'($urandom_range(2)));
      end
    end
    cycle++;
    if (cycle >= MaxCycles) begin
      stop_on_error("Simulation timed out before all tests finished");
    end
  end

  always @(negedge clk_i) begin
    mem_rsp.ready  = ($urandom % 4) != 0;
    mem_rsp.rvalid = 1'b0;
    if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
      mem_rsp.rvalid = 1'b1;
      mem_rsp.rdata  = rd_data_q.pop_front();
      void'(rd_due_q.pop_front());
    end
  end

  function automatic logic [DataWidth-1:0] fill_word(input int idx);
    return (DataWidth'(idx) * 32'h9e37_79b9) ^ 32'h5a5a_0000 ^ DataWidth'(idx);
  endfunction

  task automatic ctrl_access(input logic wr, input logic [AddrWidth-1:0] addr,
                             input logic [DataWidth-1:0] wdata,
                             output logic [DataWidth-1:0] rdata);
    ctrl_req = '{valid: 1'b1, write: wr, addr: addr, wdata: wdata};
    do @(posedge clk_i); while (!ctrl_rsp.ready);
    @(negedge clk_i);
    ctrl_req.valid = 1'b0;
    if (!ctrl_rsp.rvalid) begin
      stop_on_error("No control response one cycle after the request was accepted");
    end
    rdata = ctrl_rsp.rdata;
  endtask

  task automatic ctrl_write(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] wdata);
    logic [DataWidth-1:0] rdata;
    ctrl_access(1'b1, addr, wdata, rdata);
    check_word("write response data", '0, rdata);
  endtask

  task automatic ctrl_read(input logic [AddrWidth-1:0] addr, output logic [DataWidth-1:0] rdata);
    ctrl_access(1'b0, addr, '0, rdata);
  endtask

  task automatic read_check(input string what, input logic [AddrWidth-1:0] addr,
                            input logic [DataWidth-1:0] exp);
    logic [DataWidth-1:0] rdata;
    ctrl_read(addr, rdata);
    check_word(what, exp, rdata);
  endtask

  task automatic set_expect(input int src_w, input int dst_w, input int len,
                            input logic [DataWidth-1:0] factor);
    logic [DataWidth-1:0] prod;
    for (int i = 0; i < len; i++) begin
      prod = mem[src_w+i] * factor;
      exp_mem[dst_w+i] = prod;
    end
  endtask

  task automatic check_block(input int dst_w, input int len);
    for (int i = 0; i < len; i++) begin
      check_word($sformatf("word %0d", i), exp_mem[dst_w+i], mem[dst_w+i]);
    end
  endtask

  task automatic run_engine(input logic [AddrWidth-1:0] base, input int src_w, input int dst_w,
                            input int len);
    ctrl_write(base | RegSrc, DataWidth'(src_w * 4));
    ctrl_write(base | RegDst, DataWidth'(dst_w * 4));
    ctrl_write(base | RegLen, DataWidth'(len));
    ctrl_write(base | RegTrigger, 32'd1);
  endtask

  // Waits for one done pulse, then expects done and busy low for that engine
  task automatic wait_done(input int b);
    logic [1:0] mask;
    mask = 2'b01 << b;
    while (!done[b]) @(negedge clk_i);
    repeat (3) begin
      @(negedge clk_i);
      check_bits("done after pulse", 2'b00, done & mask);
    end
    check_bits("busy after done", 2'b00, busy & mask);
  endtask

  task automatic test_regs();
    test_name = "register access";
    read_check("owner reset", RegOwner, '0);
    read_check("enable reset", RegClkEn, '0);
    ctrl_write(RegOwner, 32'd1);
    read_check("owner", RegOwner, 32'd1);
    ctrl_write(RegOwner, 32'd0);
    ctrl_write(RegClkEn, 32'd3);
    read_check("enable", RegClkEn, 32'd3);
    ctrl_write(RegSrc, 32'h0000_0abc);
    read_check("scale src", RegSrc, 32'h0000_0abc);
    ctrl_write(CopyBase | RegDst, 32'h1234_5678);
    read_check("copy dst", CopyBase | RegDst, 32'h1234_5678);
    ctrl_write(CopyBase | RegLen, 32'd300);
    read_check("copy len", CopyBase | RegLen, 32'd300 & MaxLen);
    // Copy engine has no factor register
    ctrl_write(CopyBase | RegFactor, 32'h77);
    read_check("copy factor", CopyBase | RegFactor, '0);
    ctrl_write(RegClkEn, 32'd0);
  endtask

  task automatic test_disabled();
    test_name = "disabled engine";
    ctrl_write(RegFactor, 32'h55);
    read_check("factor while disabled", RegFactor, '0);
    ctrl_write(RegClkEn, 32'd1);
    read_check("factor after enable", RegFactor, '0);
    ctrl_write(CopyBase | RegSrc, 32'd7);
    ctrl_write(RegClkEn, 32'd3);
    read_check("copy src after enable", CopyBase | RegSrc, '0);
  endtask

  task automatic test_copy();
    test_name = "copy run";
    ctrl_write(RegOwner, 32'd1);
    set_expect(0, 256, 17, 32'd1);
    run_engine(CopyBase, 0, 256, 17);
    wait_done(1);
    check_block(256, 17);
    read_check("status", CopyBase | RegStatus, '0);
  endtask

  task automatic test_scale();
    int writes;
    test_name = "scale run";
    ctrl_write(RegOwner, 32'd0);
    ctrl_write(RegFactor, 32'd3);
    set_expect(128, 384, 9, 32'd3);
    run_engine('0, 128, 384, 9);
    wait_done(0);
    check_block(384, 9);
    test_name = "scale zero length";
    writes = wr_count;
    run_engine('0, 128, 384, 0);
    wait_done(0);
    check_word("memory writes", DataWidth'(writes), DataWidth'(wr_count));
  endtask

  task automatic test_pause();
    int writes;
    test_name = "pause";
    ctrl_write(RegFactor, 32'd5);
    set_expect(512, 640, 40, 32'd5);
    writes = wr_count;
    run_engine('0, 512, 640, 40);
    while (wr_count < writes + 5) @(negedge clk_i);
    ctrl_write(RegClkEn, 32'd2);
    writes = wr_count;
    repeat (50) @(negedge clk_i);
    check_word("writes while paused", DataWidth'(writes), DataWidth'(wr_count));
    ctrl_write(RegClkEn, 32'd3);
    wait_done(0);
    check_block(640, 40);
  endtask

  task automatic test_owner();
    test_name = "owner switch";
    copy_lo  = 700;
    copy_hi  = 760;
    copy_acc = 0;
    set_expect(800, 900, 20, 32'd5);
    set_expect(700, 740, 12, 32'd1);
    run_engine('0, 800, 900, 20);
    run_engine(CopyBase, 700, 740, 12);
    wait_done(0);
    check_word("copy accesses before switch", '0, DataWidth'(copy_acc));
    check_bits("busy before switch", 2'b10, busy);
    ctrl_write(RegOwner, 32'd1);
    wait_done(1);
    check_block(900, 20);
    check_block(740, 12);
  endtask

  initial begin
    void'($urandom(32'h7cd9_546b));
    ctrl_req = '0;
    mem_rsp  = '0;
    rst_ni   = 1'b0;
    for (int i = 0; i < MemWords; i++) begin
      mem[i]     = fill_word(i);
      exp_mem[i] = mem[i];
    end
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    test_name = "reset";
    check_bits("busy after reset", 2'b00, busy);
    check_bits("done after reset", 2'b00, done);
    check_bits("mem valid and ctrl rvalid after reset", 2'b00,
               {mem_req.valid, ctrl_rsp.rvalid});
    test_regs();
    test_disabled();
    test_copy();
    test_scale();
    test_pause();
    test_owner();
    $display("All checks passed");
    $finish;
  end

endmodule

bind hwpe_subsystem tb_hwpe_assert i_hwpe_assert (.*);

// ==== build.f ====
hwpe_pkg.sv
mem_port_mux.sv
scale_engine.sv
copy_engine.sv
hwpe_subsystem.sv
tb_hwpe_assert.sv
tb_hwpe_subsystem.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_hwpe_subsystem \
  -o sim_tb > build.log 2>&1 && ./obj_dir/sim_tb > sim.log 2>&1 \
  || echo "Checks failed" >> sim.log
cat sim.log
grep -q "Checks failed" sim.log && exit 1 || grep -q "All checks passed" sim.log
